//--- filelist.f
design/station_pkg.sv
design/i2c_pkg.sv
design/i2c_master.sv
design/sensor_poller.sv
design/sensor_station.sv
tb/i2c_sensor_model.sv
tb/tb_sensor_station.sv

//--- Bender.yml
package:
  name: sensor_station

sources:
  - design/station_pkg.sv
  - design/i2c_pkg.sv
  - design/i2c_master.sv
  - design/sensor_poller.sv
  - design/sensor_station.sv
  - target: test
    files:
      - tb/i2c_sensor_model.sv
      - tb/tb_sensor_station.sv

//--- tb/tb_sensor_station.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_station
	import station_pkg::*;
	import i2c_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int ROUNDS = 6;
	localparam int NACK_ROUND = 4;
	localparam int SCL_PERIOD = 2 * SCL_HALF_CYCLES * CLK_PERIOD;
	localparam int TIMEOUT = ROUNDS * SENSOR_COUNT * 32 * SCL_PERIOD + 16 * CLK_PERIOD + 2000;

	logic clk;
	logic rst;
	wire sda;
	wire scl;
	celsius_t solar_c;
	celsius_t greenhouse_c;
	celsius_t ambient_c;
	celsius_t geothermal_c;
	lux_t north_lux;
	lux_t east_lux;
	lux_t south_lux;
	lux_t west_lux;
	logic sweep_done;
	logic sweep_q;
	logic [16*SENSOR_COUNT-1:0] words;
	logic [SENSOR_COUNT-1:0] ack_en;
	int starts;
	int addr_count;
	int stops;
	logic order_error;
	logic [15:0] lfsr;
	celsius_t exp_temp [4];
	lux_t exp_lux [4];

	pullup (sda);
	pullup (scl);

	sensor_station dut0 (
		.clk(clk),
		.rst(rst),
		.sda(sda),
		.scl(scl),
		.solar_c(solar_c),
		.greenhouse_c(greenhouse_c),
		.ambient_c(ambient_c),
		.geothermal_c(geothermal_c),
		.north_lux(north_lux),
		.east_lux(east_lux),
		.south_lux(south_lux),
		.west_lux(west_lux),
		.sweep_done(sweep_done)
	);

	i2c_sensor_model model0 (
		.sda(sda),
		.scl(scl),
		.words(words),
		.ack_en(ack_en),
		.starts(starts),
		.addr_count(addr_count),
		.stops(stops),
		.order_error(order_error)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("Checks failed");
		$fatal(1, "stopping at the first error");
	endtask

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic celsius_t temp_at(input int i);
		case (i)
			0: return solar_c;
			1: return greenhouse_c;
			2: return ambient_c;
			default: return geothermal_c;
		endcase
	endfunction

	function automatic lux_t lux_at(input int i);
		case (i)
			0: return north_lux;
			1: return east_lux;
			2: return south_lux;
			default: return west_lux;
		endcase
	endfunction

	function automatic logic outputs_zero();
		logic z;
		z = 1'b1;
		for (int i = 0; i < 4; i++)
			z = z && (temp_at(i) == 0) && (lux_at(i) == 0);
		return z;
	endfunction

	// Next round's words, plus what the outputs should show after it
	task automatic load_round(input int r);
		logic [15:0] w;
		int skip_temp;
		int skip_light;
		int step;
		skip_temp = -1;
		skip_light = -1;
		if (r == NACK_ROUND)
		begin
			skip_temp = random_bits(2);
			skip_light = 4 + random_bits(2);
		end
		for (int i = 0; i < SENSOR_COUNT; i++)
		begin
			w = random_bits(16);
			if (i >= 4 && r < 4)
				w[15:12] = 4'(4 * r + i - 4);   // Sweep every exponent once
			if (r == 0 && i == 0)
				w[15] = 1'b1;                    // A sub-zero reading
			words[16*i +: 16] <= w;
			ack_en[i] <= (i != skip_temp && i != skip_light);
			if (i != skip_temp && i != skip_light)
			begin
				if (i < 4)
					exp_temp[i] = $signed(w[15:8]);
				else
				begin
					step = (1 << w[15:12]) / 100;
					exp_lux[i-4] = lux_t'(step * w[11:0]);
				end
			end
		end
	endtask

	task automatic check_round(input int r);
		for (int i = 0; i < 4; i++)
		begin
			assert (temp_at(i) == exp_temp[i])
			else
				report_failure($sformatf("round %0d temperature %0d is %0d, expected %0d",
					r, i, temp_at(i), exp_temp[i]));
			assert (lux_at(i) == exp_lux[i])
			else
				report_failure($sformatf("round %0d light %0d is %0d, expected %0d",
					r, i, lux_at(i), exp_lux[i]));
		end
		assert (addr_count == SENSOR_COUNT * (r + 1))
		else
			report_failure($sformatf("sweep_done after %0d bus reads in round %0d", addr_count, r));
	endtask

	always @(posedge clk)
	begin
		if (!rst)
		begin
			assert (!(sweep_done && sweep_q))
			else
				report_failure("sweep_done wider than one cycle");
			if (stops == 0)
				assert (!sweep_done && outputs_zero())
				else
					report_failure("outputs moved before the first transaction");
			if (starts == 0)
				assert (sda === 1'b1 && scl === 1'b1)
				else
					report_failure("bus not idle high before the first start");
			assert (!order_error)
			else
				report_failure("bus address out of polling order or without read bit");
		end
		sweep_q <= sweep_done;
	end

	initial
	begin
		#(TIMEOUT);
		$display("Timeout: the sensor sweeps did not finish in time");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		lfsr = 16'd47257;
		rst = 1'b1;
		load_round(0);
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < ROUNDS; r++)
		begin
			do
				@(posedge clk);
			while (!sweep_done);
			check_round(r);
			if (r + 1 < ROUNDS)
				load_round(r + 1);
		end
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/i2c_sensor_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_sensor_model
	import station_pkg::*;
	import i2c_pkg::*;
(
	inout wire sda,
	input wire scl,
	input wire logic [16*SENSOR_COUNT-1:0] words,   // Served word per polling slot
	input wire logic [SENSOR_COUNT-1:0] ack_en,      // Address acknowledge per slot
	output int starts,
	output int addr_count,
	output int stops,
	output logic order_error
);

	logic sda_drive;
	logic active;                // Between start and stop
	logic selected;              // Addressed and acknowledging
	logic [7:0] addr_byte;
	int edge_cnt;                // SCL rises since start
	int hit_idx;
	sensor_idx_t exp_idx;        // Next slot in polling order

	assign sda = sda_drive ? 1'b0 : 1'bz;

	function automatic int lookup_slot(input i2c_addr_t a);
		int slot;
		slot = -1;
		for (int i = 0; i < SENSOR_COUNT; i++)
			if (SENSOR_ADDR[i] == a)
				slot = i;
		return slot;
	endfunction

	initial
	begin
		sda_drive = 1'b0;
		active = 1'b0;
		selected = 1'b0;
		edge_cnt = 0;
		hit_idx = 0;
		exp_idx = '0;
		starts = 0;
		addr_count = 0;
		stops = 0;
		order_error = 1'b0;
	end

	always @(negedge sda)
	begin
		if (scl === 1'b1 && sda === 1'b0)   // Start condition
		begin
			active = 1'b1;
			selected = 1'b0;
			edge_cnt = 0;
			starts = starts + 1;
		end
	end

	always @(posedge sda)
	begin
		if (scl === 1'b1 && active)   // Stop condition
		begin
			active = 1'b0;
			sda_drive = 1'b0;
			stops = stops + 1;
		end
	end

	always @(posedge scl)
	begin
		if (active)
		begin
			edge_cnt = edge_cnt + 1;
			if (edge_cnt <= 8)
				addr_byte = {addr_byte[6:0], sda};
			if (edge_cnt == 8)
			begin
				assert (addr_byte[7:1] == SENSOR_ADDR[exp_idx] && addr_byte[0])
				else
					order_error = 1'b1;
				hit_idx = lookup_slot(addr_byte[7:1]);
				selected = 1'b0;
				if (hit_idx >= 0)
					selected = ack_en[hit_idx];
				addr_count = addr_count + 1;
				exp_idx = exp_idx + 1'b1;
			end
		end
	end

	// SDA only moves while SCL is low
	always @(negedge scl)
	begin
		if (active)
		begin
			sda_drive = 1'b0;
			if (edge_cnt == 8)
				sda_drive = selected;
			else if (selected && edge_cnt >= 9 && edge_cnt <= 16)
				sda_drive = ~words[hit_idx*16 + 24 - edge_cnt];   // High byte
			else if (selected && edge_cnt >= 18 && edge_cnt <= 25)
				sda_drive = ~words[hit_idx*16 + 25 - edge_cnt];   // Low byte
		end
	end

endmodule

`default_nettype wire

//--- design/sensor_station.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_station
	import station_pkg::*;
	import i2c_pkg::*;
(
	input wire clk,
	input wire rst,
	inout wire sda,
	inout wire scl,
	output celsius_t solar_c,
	output celsius_t greenhouse_c,
	output celsius_t ambient_c,
	output celsius_t geothermal_c,
	output lux_t north_lux,
	output lux_t east_lux,
	output lux_t south_lux,
	output lux_t west_lux,
	output logic sweep_done
);

	logic start;
	logic ready;
	logic ack;
	i2c_addr_t addr;
	sensor_word_t read_data;

	sensor_poller poller0 (
		.clk(clk),
		.rst(rst),
		.ready(ready),
		.ack(ack),
		.read_data(read_data),
		.start(start),
		.addr(addr),
		.solar_c(solar_c),
		.greenhouse_c(greenhouse_c),
		.ambient_c(ambient_c),
		.geothermal_c(geothermal_c),
		.north_lux(north_lux),
		.east_lux(east_lux),
		.south_lux(south_lux),
		.west_lux(west_lux),
		.sweep_done(sweep_done)
	);

	i2c_master master0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.addr(addr),
		.sda(sda),
		.scl(scl),
		.read_data(read_data),
		.ready(ready),
		.ack(ack)
	);

endmodule

`default_nettype wire

//--- design/sensor_poller.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_poller
	import station_pkg::*;
	import i2c_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire logic ready,
	input wire logic ack,
	input wire sensor_word_t read_data,
	output logic start,
	output i2c_addr_t addr,
	output celsius_t solar_c,
	output celsius_t greenhouse_c,
	output celsius_t ambient_c,
	output celsius_t geothermal_c,
	output lux_t north_lux,
	output lux_t east_lux,
	output lux_t south_lux,
	output lux_t west_lux,
	output logic sweep_done
);

	typedef enum logic {LAUNCH, WAIT} poll_state_t;

	poll_state_t state;
	sensor_idx_t idx;
	logic ready_q;
	logic done;              // Transaction just finished
	logic [3:0] exponent;
	logic [11:0] mantissa;
	lux_t lux_step;
	lux_t lux_value;
	celsius_t temp_value;

	assign addr = SENSOR_ADDR[idx];
	assign done = (state == WAIT) && ready && !ready_q;

	assign exponent = read_data[15:12];
	assign mantissa = read_data[11:0];
	assign lux_step = (16'd1 << exponent) / 16'd100;   // Zero below exponent 7
	assign lux_value = lux_step * lux_t'(mantissa);    // Truncated to 16 bits
	assign temp_value = celsius_t'(read_data[15:8]);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= LAUNCH;
			idx <= '0;
			ready_q <= 1'b1;
			start <= 1'b0;
			sweep_done <= 1'b0;
		end
		else
		begin
			ready_q <= ready;
			start <= 1'b0;
			sweep_done <= 1'b0;
			case (state)
				LAUNCH:
				begin
					if (ready)
					begin
						start <= 1'b1;
						state <= WAIT;
					end
				end
				WAIT:
				begin
					if (done)
					begin
						sweep_done <= (idx == sensor_idx_t'(SENSOR_COUNT - 1));
						idx <= idx + 1'b1;   // Wraps to solar
						state <= LAUNCH;
					end
				end
				default:
					state <= LAUNCH;
			endcase
		end
	end

	// Last good values, a missing ACK leaves the slot alone
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			solar_c <= '0;
			greenhouse_c <= '0;
			ambient_c <= '0;
			geothermal_c <= '0;
			north_lux <= '0;
			east_lux <= '0;
			south_lux <= '0;
			west_lux <= '0;
		end
		else if (done && ack)
		begin
			case (idx)
				3'd0: solar_c <= temp_value;
				3'd1: greenhouse_c <= temp_value;
				3'd2: ambient_c <= temp_value;
				3'd3: geothermal_c <= temp_value;
				3'd4: north_lux <= lux_value;
				3'd5: east_lux <= lux_value;
				3'd6: south_lux <= lux_value;
				default: west_lux <= lux_value;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master
	import station_pkg::*;
	import i2c_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire logic start,
	input wire i2c_addr_t addr,
	inout wire sda,
	inout wire scl,
	output sensor_word_t read_data,
	output logic ready,
	output logic ack
);

	i2c_state_t state;
	logic [SCL_DIV_W-1:0] div_cnt;
	logic phase;                 // Set during SCL high half
	logic [2:0] bit_cnt;
	logic second_byte;
	logic [7:0] tx_sh;           // Address and read bit
	logic scl_low;
	logic sda_low;
	logic tick;
	logic mid;
	logic bit_state;

	assign tick = (div_cnt == SCL_DIV_W'(SCL_HALF_CYCLES - 1));
	assign mid = (div_cnt == SCL_DIV_W'(SDA_SHIFT_CYCLE));
	assign bit_state = (state inside {ST_ADDR, ST_ADDR_ACK, ST_READ, ST_MASTER_ACK, ST_STOP});

	// Open drain, pull-ups supply the high level
	assign scl = scl_low ? 1'b0 : 1'bz;
	assign sda = sda_low ? 1'b0 : 1'bz;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			div_cnt <= '0;
		else if (state == ST_IDLE || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && start)
			tx_sh <= {addr, 1'b1};
		else if (state == ST_ADDR && phase && tick)
			tx_sh <= {tx_sh[6:0], 1'b0};
		if (state == ST_READ && phase && tick)
			read_data <= {read_data[14:0], sda};   // MSB first
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			phase <= 1'b0;
			bit_cnt <= '0;
			second_byte <= 1'b0;
			scl_low <= 1'b0;
			sda_low <= 1'b0;
			ready <= 1'b1;
			ack <= 1'b0;
		end
		else
		begin
			// Each bit is an SCL low half then a high half
			if (bit_state && tick)
			begin
				phase <= ~phase;
				scl_low <= phase;
			end
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						sda_low <= 1'b1;   // Start condition, SCL still high
						ready <= 1'b0;
						state <= ST_START;
					end
				end
				ST_START:
				begin
					if (tick)
					begin
						scl_low <= 1'b1;
						phase <= 1'b0;
						bit_cnt <= 3'd7;
						state <= ST_ADDR;
					end
				end
				ST_ADDR:
				begin
					if (!phase && mid)
						sda_low <= ~tx_sh[7];
					if (phase && tick)
					begin
						if (bit_cnt == 3'd0)
							state <= ST_ADDR_ACK;
						else
							bit_cnt <= bit_cnt - 1'b1;
					end
				end
				ST_ADDR_ACK:
				begin
					if (!phase && mid)
						sda_low <= 1'b0;   // Let the target answer
					if (phase && tick)
					begin
						ack <= ~sda;
						if (sda)
							state <= ST_STOP;   // No target, abort
						else
						begin
							bit_cnt <= 3'd7;
							second_byte <= 1'b0;
							state <= ST_READ;
						end
					end
				end
				ST_READ:
				begin
					if (!phase && mid)
						sda_low <= 1'b0;
					if (phase && tick)
					begin
						if (bit_cnt == 3'd0)
							state <= ST_MASTER_ACK;
						else
							bit_cnt <= bit_cnt - 1'b1;
					end
				end
				ST_MASTER_ACK:
				begin
					if (!phase && mid)
						sda_low <= ~second_byte;   // ACK first byte, NACK the last
					if (phase && tick)
					begin
						if (second_byte)
							state <= ST_STOP;
						else
						begin
							second_byte <= 1'b1;
							bit_cnt <= 3'd7;
							state <= ST_READ;
						end
					end
				end
				ST_STOP:
				begin
					if (!phase && mid)
						sda_low <= 1'b1;
					if (phase && tick)
					begin
						scl_low <= 1'b0;   // Keep SCL released
						sda_low <= 1'b0;   // SDA rises with SCL high
						state <= ST_FREE;
					end
				end
				ST_FREE:
				begin
					// Bus free time before the next start
					if (tick)
					begin
						ready <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	typedef logic [6:0] i2c_addr_t;

	localparam int SCL_HALF_CYCLES = 4;                         // Clk cycles per SCL half period
	localparam int SCL_DIV_W       = $clog2(SCL_HALF_CYCLES);
	localparam int SDA_SHIFT_CYCLE = SCL_HALF_CYCLES / 2 - 1;   // SDA moves mid low half

	typedef enum logic [2:0]
	{
		ST_IDLE, ST_START, ST_ADDR, ST_ADDR_ACK,
		ST_READ, ST_MASTER_ACK, ST_STOP, ST_FREE
	} i2c_state_t;

endpackage

`default_nettype wire

//--- design/station_pkg.sv
`default_nettype none

package station_pkg;

	typedef logic signed [7:0] celsius_t;     // Whole degrees Celsius
	typedef logic [15:0] lux_t;
	typedef logic [15:0] sensor_word_t;       // Raw two-byte read
	typedef logic [2:0] sensor_idx_t;

	localparam int SENSOR_COUNT = 8;

	localparam logic [6:0] SOLAR_ADDR      = 7'b1001000;
	localparam logic [6:0] GREENHOUSE_ADDR = 7'b1001001;
	localparam logic [6:0] AMBIENT_ADDR    = 7'b1001010;
	localparam logic [6:0] GEOTHERMAL_ADDR = 7'b1001011;
	localparam logic [6:0] NORTH_ADDR      = 7'b1000100;
	localparam logic [6:0] EAST_ADDR       = 7'b1000101;
	localparam logic [6:0] SOUTH_ADDR      = 7'b1000110;
	localparam logic [6:0] WEST_ADDR       = 7'b1000111;

	// Temperatures occupy slots 0 to 3, light sensors 4 to 7
	localparam logic [6:0] SENSOR_ADDR [SENSOR_COUNT] = '{
		SOLAR_ADDR, GREENHOUSE_ADDR, AMBIENT_ADDR, GEOTHERMAL_ADDR,
		NORTH_ADDR, EAST_ADDR, SOUTH_ADDR, WEST_ADDR
	};

endpackage

`default_nettype wire
